/* verilog/cache_pkg.sv */
// Shared definitions for the set-associative cache memory array
// Geometry constants, request command encoding and the address/block types
// Modules import this package in their bodies and use scoped names in port lists
// The address union gives a flat view and a tag/index/offset view of one word

`default_nettype none

package cache_pkg;

    // ==============================
    // Geometry
    // ==============================

    // Address width in bits
    localparam int XLEN       = 32;
    // Sets and ways
    localparam int NUM_SETS   = 4;
    localparam int NUM_WAYS   = 4;
    // One block per line, 8 bytes
    localparam int BLOCK_BITS = 64;
    // Byte offset inside a block
    localparam int OFFSET_W   = 3;
    // Set index width
    localparam int INDEX_W    = $clog2(NUM_SETS);
    // Tag takes the remaining upper bits
    localparam int TAG_W      = XLEN - INDEX_W - OFFSET_W;
    // Way index width
    localparam int WAY_W      = $clog2(NUM_WAYS);
    // One history bit per pair of ways
    localparam int HIST_W     = (NUM_WAYS * (NUM_WAYS - 1)) / 2;

    // ==============================
    // Types
    // ==============================

    // Request command, held as a level for one cycle
    typedef enum logic [2:0] {
        REQ_NONE       = 3'd0,
        REQ_LOAD       = 3'd1,
        REQ_STORE      = 3'd2,
        REQ_LOAD_MISS  = 3'd3,
        REQ_STORE_MISS = 3'd4
    } req_cmd_e;

    typedef logic [BLOCK_BITS-1:0] cache_block_t;
    typedef logic [TAG_W-1:0]      cache_tag_t;
    typedef logic [WAY_W-1:0]      way_idx_t;
    typedef logic [INDEX_W-1:0]    set_idx_t;

    // Field view of an address, MSB first
    typedef struct packed {
        cache_tag_t          tag;
        set_idx_t            index;
        logic [OFFSET_W-1:0] offset;
    } cache_addr_fields_t;

    // Address word, either flat or split into fields
    typedef union packed {
        logic [XLEN-1:0]    raw;
        cache_addr_fields_t fields;
    } cache_addr_u;

endpackage

`default_nettype wire

/* verilog/way_lookup.sv */
// Tag lookup across all ways of the addressed set
// Purely combinational on the current array contents
// Reports whether a valid way holds the request tag, which way, and its block
// The block offset of the request is ignored

`timescale 1ns/1ps
`default_nettype none

module way_lookup (
    input  wire cache_pkg::cache_addr_u req_addr_i,
    input  wire logic [cache_pkg::NUM_SETS-1:0][cache_pkg::NUM_WAYS-1:0] valid_array_i,
    input  wire cache_pkg::cache_tag_t [cache_pkg::NUM_SETS-1:0][cache_pkg::NUM_WAYS-1:0]
                                        tag_array_i,
    input  wire cache_pkg::cache_block_t [cache_pkg::NUM_SETS-1:0][cache_pkg::NUM_WAYS-1:0]
                                        data_array_i,
    output logic                        hit_o,
    output cache_pkg::way_idx_t         hit_way_o,
    output cache_pkg::cache_block_t     hit_data_o
);

    import cache_pkg::*;

    // Request fields
    set_idx_t   req_set;
    cache_tag_t req_tag;

    // Match vector for the addressed set
    logic [NUM_WAYS-1:0] way_match;

    assign req_set = req_addr_i.fields.index;
    assign req_tag = req_addr_i.fields.tag;

    // Compare the tag against every valid way
    always_comb begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            way_match[w] = valid_array_i[req_set][w] && (tag_array_i[req_set][w] == req_tag);
        end
    end

    // ==============================
    // Hit mux
    // ==============================

    // At most one way matches, tags in a set are unique
    always_comb begin
        hit_o      = 1'b0;
        hit_way_o  = '0;
        hit_data_o = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (way_match[w]) begin
                hit_o      = 1'b1;
                hit_way_o  = way_idx_t'(w);
                hit_data_o = data_array_i[req_set][w];
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/victim_select.sv */
// Replacement state and victim choice for the cache
// Keeps a pairwise use-history matrix per set, one bit per pair of ways
// Gives the highest-numbered empty way and the least recently used way of set_i
// A use strobe moves the given way to most recently used at the clock edge
// Pair bit (lo, hi) is 0 when way lo was used after way hi, 1 otherwise

`timescale 1ns/1ps
`default_nettype none

module victim_select (
    input  wire logic                 clk_i,
    input  wire logic                 rst_i,
    input  wire cache_pkg::set_idx_t  set_i,
    input  wire logic [cache_pkg::NUM_SETS-1:0][cache_pkg::NUM_WAYS-1:0] valid_array_i,
    input  wire logic                 use_valid_i,
    input  wire cache_pkg::way_idx_t  use_way_i,
    output logic                      empty_valid_o,
    output cache_pkg::way_idx_t       empty_way_o,
    output cache_pkg::way_idx_t       lru_way_o
);

    import cache_pkg::*;

    // ==============================
    // State
    // ==============================

    // Use history per set
    logic [NUM_SETS-1:0][HIST_W-1:0] hist_q;

    // History of the addressed set, current and after a use
    logic [HIST_W-1:0] hist_set;
    logic [HIST_W-1:0] hist_next;

    // Per way, set when that way loses every pair
    logic [NUM_WAYS-1:0] loses_all;

    // Bit position of pair (lo, hi), lo < hi
    // Pairs are packed row by row, (0,1) (0,2) (0,3) (1,2) (1,3) (2,3)
    function automatic int pair_idx(input int lo, input int hi);
        return lo * NUM_WAYS - (lo * (lo + 1)) / 2 + (hi - lo - 1);
    endfunction

    assign hist_set = hist_q[set_i];

    // ==============================
    // Empty way finder
    // ==============================

    // Ascending scan, last invalid way wins
    always_comb begin
        empty_valid_o = 1'b0;
        empty_way_o   = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (!valid_array_i[set_i][w]) begin
                empty_valid_o = 1'b1;
                empty_way_o   = way_idx_t'(w);
            end
        end
    end

    // ==============================
    // LRU choice
    // ==============================

    // A way is LRU when every other way was used after it
    always_comb begin
        loses_all = '1;
        for (int w = 0; w < NUM_WAYS; w++) begin
            for (int o = 0; o < NUM_WAYS; o++) begin
                if (w < o) begin
                    // Bit 1 means the higher way o is more recent
                    loses_all[w] = loses_all[w] & hist_set[pair_idx(w, o)];
                end else if (o < w) begin
                    // Bit 0 means the lower way o is more recent
                    loses_all[w] = loses_all[w] & ~hist_set[pair_idx(o, w)];
                end
            end
        end
    end

    // History is a total order, so exactly one way loses all pairs
    always_comb begin
        lru_way_o = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (loses_all[w]) begin
                lru_way_o = way_idx_t'(w);
            end
        end
    end

    // ==============================
    // History update
    // ==============================

    // Every pair holding the used way now favors it
    always_comb begin
        hist_next = hist_set;
        for (int o = 0; o < NUM_WAYS; o++) begin
            if (o < int'(use_way_i)) begin
                hist_next[pair_idx(o, int'(use_way_i))] = 1'b1;
            end else if (o > int'(use_way_i)) begin
                hist_next[pair_idx(int'(use_way_i), o)] = 1'b0;
            end
        end
    end

    // All zero after reset, giving order 0 1 2 3 with way 3 as LRU
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            hist_q <= '0;
        end else if (use_valid_i) begin
            hist_q[set_i] <= hist_next;
        end
    end

endmodule

`default_nettype wire

/* verilog/line_update.sv */
// Line storage and request decoding for the cache
// Holds the valid, dirty, tag and data arrays of all sets and ways
// Combines the lookup and victim results into writes, responses and evictions
// Responses are combinational, array writes land at the next rising edge
// Fills go to an empty way first, else to the LRU way, which is then reported

`timescale 1ns/1ps
`default_nettype none

module line_update (
    input  wire logic                   clk_i,
    input  wire logic                   rst_i,
    input  wire cache_pkg::req_cmd_e    req_cmd_i,
    input  wire cache_pkg::cache_addr_u req_addr_i,
    input  wire cache_pkg::cache_block_t req_data_i,
    input  wire logic                   hit_i,
    input  wire cache_pkg::way_idx_t    hit_way_i,
    input  wire cache_pkg::cache_block_t hit_data_i,
    input  wire logic                   empty_valid_i,
    input  wire cache_pkg::way_idx_t    empty_way_i,
    input  wire cache_pkg::way_idx_t    lru_way_i,
    output logic [cache_pkg::NUM_SETS-1:0][cache_pkg::NUM_WAYS-1:0] valid_array_o,
    output cache_pkg::cache_tag_t [cache_pkg::NUM_SETS-1:0][cache_pkg::NUM_WAYS-1:0]
                                        tag_array_o,
    output cache_pkg::cache_block_t [cache_pkg::NUM_SETS-1:0][cache_pkg::NUM_WAYS-1:0]
                                        data_array_o,
    output logic                        use_valid_o,
    output cache_pkg::way_idx_t         use_way_o,
    output logic                        req_hit_o,
    output cache_pkg::cache_block_t     req_data_o,
    output logic                        evict_valid_o,
    output logic                        evict_dirty_o,
    output cache_pkg::cache_addr_u      evict_addr_o,
    output cache_pkg::cache_block_t     evict_data_o
);

    import cache_pkg::*;

    // ==============================
    // Arrays
    // ==============================

    // Control bits, cleared on reset
    logic [NUM_SETS-1:0][NUM_WAYS-1:0] valid_q;
    logic [NUM_SETS-1:0][NUM_WAYS-1:0] dirty_q;
    // Payload
    cache_tag_t   [NUM_SETS-1:0][NUM_WAYS-1:0] tag_q;
    cache_block_t [NUM_SETS-1:0][NUM_WAYS-1:0] data_q;

    // Request fields
    set_idx_t   req_set;
    cache_tag_t req_tag;

    // Command decode
    logic cmd_active;
    logic cmd_write;
    logic cmd_fill;
    logic hit_write;
    logic fill_write;
    way_idx_t fill_way;

    assign req_set = req_addr_i.fields.index;
    assign req_tag = req_addr_i.fields.tag;

    // Store and store-miss both write on a hit
    assign cmd_active = (req_cmd_i != REQ_NONE);
    assign cmd_write  = (req_cmd_i == REQ_STORE) || (req_cmd_i == REQ_STORE_MISS);
    assign cmd_fill   = (req_cmd_i == REQ_LOAD_MISS) || (req_cmd_i == REQ_STORE_MISS);

    assign hit_write  = cmd_write && hit_i;
    // Miss fill only when the block is still absent
    assign fill_write = cmd_fill && !hit_i;
    // Empty way has priority over the LRU victim
    assign fill_way   = empty_valid_i ? empty_way_i : lru_way_i;

    // ==============================
    // Responses
    // ==============================

    assign req_hit_o  = cmd_active && hit_i;
    // Old block contents, also for a store
    assign req_data_o = req_hit_o ? hit_data_i : '0;

    // Hit way or fill way becomes most recently used
    assign use_valid_o = req_hit_o || fill_write;
    assign use_way_o   = hit_i ? hit_way_i : fill_way;

    // Eviction only when a fill finds the set full
    assign evict_valid_o = fill_write && !empty_valid_i;

    always_comb begin
        evict_addr_o  = '0;
        evict_dirty_o = 1'b0;
        evict_data_o  = '0;
        if (evict_valid_o) begin
            // Victim address rebuilt from its tag and the set, offset zero
            evict_addr_o.fields.tag    = tag_q[req_set][lru_way_i];
            evict_addr_o.fields.index  = req_set;
            evict_addr_o.fields.offset = '0;
            evict_dirty_o              = dirty_q[req_set][lru_way_i];
            evict_data_o               = data_q[req_set][lru_way_i];
        end
    end

    // ==============================
    // Array writes
    // ==============================

    // Valid and dirty bits
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (fill_write) begin
            valid_q[req_set][fill_way] <= 1'b1;
            // New line is dirty only for a store-miss fill
            dirty_q[req_set][fill_way] <= (req_cmd_i == REQ_STORE_MISS);
        end else if (hit_write) begin
            dirty_q[req_set][hit_way_i] <= 1'b1;
        end
    end

    // Tag and data
    always_ff @(posedge clk_i) begin
        if (fill_write) begin
            tag_q[req_set][fill_way]  <= req_tag;
            data_q[req_set][fill_way] <= req_data_i;
        end else if (hit_write) begin
            data_q[req_set][hit_way_i] <= req_data_i;
        end
    end

    // Current contents to lookup and victim selection
    assign valid_array_o = valid_q;
    assign tag_array_o   = tag_q;
    assign data_array_o  = data_q;

endmodule

`default_nettype wire

/* verilog/cache_mem.sv */
// Top level of the 4-set, 4-way cache memory array
// One request per cycle as a command level, no handshake
// Responses and eviction reports come back in the same cycle
// State changes from a request are visible to the next request

`timescale 1ns/1ps
`default_nettype none

module cache_mem (
    input  wire logic                    clk_i,
    input  wire logic                    rst_i,
    input  wire cache_pkg::req_cmd_e     req_cmd_i,
    input  wire cache_pkg::cache_addr_u  req_addr_i,
    input  wire cache_pkg::cache_block_t req_data_i,
    output logic                         req_hit_o,
    output cache_pkg::cache_block_t      req_data_o,
    output logic                         evict_valid_o,
    output logic                         evict_dirty_o,
    output cache_pkg::cache_addr_u       evict_addr_o,
    output cache_pkg::cache_block_t      evict_data_o
);

    import cache_pkg::*;

    // ==============================
    // Internal nets
    // ==============================

    // Array contents from line_update
    logic         [NUM_SETS-1:0][NUM_WAYS-1:0] valid_array;
    cache_tag_t   [NUM_SETS-1:0][NUM_WAYS-1:0] tag_array;
    cache_block_t [NUM_SETS-1:0][NUM_WAYS-1:0] data_array;

    // Lookup result
    logic         hit;
    way_idx_t     hit_way;
    cache_block_t hit_data;

    // Victim choice for the addressed set
    logic     empty_valid;
    way_idx_t empty_way;
    way_idx_t lru_way;

    // Way to mark most recently used
    logic     use_valid;
    way_idx_t use_way;

    way_lookup u_way_lookup (
        .req_addr_i    (req_addr_i),
        .valid_array_i (valid_array),
        .tag_array_i   (tag_array),
        .data_array_i  (data_array),
        .hit_o         (hit),
        .hit_way_o     (hit_way),
        .hit_data_o    (hit_data)
    );

    victim_select u_victim_select (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .set_i         (req_addr_i.fields.index),
        .valid_array_i (valid_array),
        .use_valid_i   (use_valid),
        .use_way_i     (use_way),
        .empty_valid_o (empty_valid),
        .empty_way_o   (empty_way),
        .lru_way_o     (lru_way)
    );

    line_update u_line_update (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .req_cmd_i     (req_cmd_i),
        .req_addr_i    (req_addr_i),
        .req_data_i    (req_data_i),
        .hit_i         (hit),
        .hit_way_i     (hit_way),
        .hit_data_i    (hit_data),
        .empty_valid_i (empty_valid),
        .empty_way_i   (empty_way),
        .lru_way_i     (lru_way),
        .valid_array_o (valid_array),
        .tag_array_o   (tag_array),
        .data_array_o  (data_array),
        .use_valid_o   (use_valid),
        .use_way_o     (use_way),
        .req_hit_o     (req_hit_o),
        .req_data_o    (req_data_o),
        .evict_valid_o (evict_valid_o),
        .evict_dirty_o (evict_dirty_o),
        .evict_addr_o  (evict_addr_o),
        .evict_data_o  (evict_data_o)
    );

endmodule

`default_nettype wire

/* verif/cache_mem_tb.sv */
// Testbench for the 4-set, 4-way cache memory array
// Reads request vectors and expected responses from verif/cache_input.txt
// Drives one request per clock and checks the same-cycle responses
// Prints one line per vector and a closing count line

`timescale 1ns/1ps
`default_nettype none

module cache_mem_tb;

    import cache_pkg::*;

    // ==============================
    // Timing and limits
    // ==============================

    localparam int    CLK_HALF     = 4;
    localparam int    CLK_PERIOD   = 2 * CLK_HALF;
    localparam int    RST_CYCLES   = 5;
    // Inputs change just after the edge, outputs are read just before the next
    localparam int    DRIVE_DLY    = 1;
    localparam int    SAMPLE_DLY   = CLK_PERIOD - DRIVE_DLY - 1;
    // Extra cycles on top of the vector count, covers reset
    localparam int    SLACK_CYCLES = 20;
    localparam string VEC_FILE     = "verif/cache_input.txt";

    // DUT connections
    logic         clk;
    logic         rst;
    req_cmd_e     req_cmd;
    cache_addr_u  req_addr;
    cache_block_t req_data;
    logic         req_hit;
    cache_block_t req_rdata;
    logic         evict_valid;
    logic         evict_dirty;
    cache_addr_u  evict_addr;
    cache_block_t evict_data;

    // One entry per request line of the vector file
    logic [2:0]   vec_cmd[$];
    logic [31:0]  vec_addr[$];
    cache_block_t vec_data[$];
    logic         vec_hit[$];
    cache_block_t vec_rdata[$];
    logic         vec_ev_valid[$];
    logic         vec_ev_dirty[$];
    logic [31:0]  vec_ev_addr[$];
    cache_block_t vec_ev_data[$];

    // Bookkeeping
    int vec_idx;
    int vec_errors;
    int pass_count;
    int fail_count;
    bit load_error;
    bit loaded;

    cache_mem UUT (
        .clk_i         (clk),
        .rst_i         (rst),
        .req_cmd_i     (req_cmd),
        .req_addr_i    (req_addr),
        .req_data_i    (req_data),
        .req_hit_o     (req_hit),
        .req_data_o    (req_rdata),
        .evict_valid_o (evict_valid),
        .evict_dirty_o (evict_dirty),
        .evict_addr_o  (evict_addr),
        .evict_data_o  (evict_data)
    );

    always #CLK_HALF clk = ~clk;

    // ==============================
    // Compare tasks
    // ==============================

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("error in %s at vector %0d: expected 0x%h, actual 0x%h",
                     name, vec_idx, expected, actual);
            vec_errors++;
        end
    endtask

    task automatic check_block(input string name, input cache_block_t expected,
                               input cache_block_t actual);
        if (actual !== expected) begin
            $display("error in %s at vector %0d: expected 0x%h, actual 0x%h",
                     name, vec_idx, expected, actual);
            vec_errors++;
        end
    endtask

    task automatic check_addr(input string name, input cache_addr_u expected,
                              input cache_addr_u actual);
        if (actual.raw !== expected.raw) begin
            $display("error in %s at vector %0d: expected 0x%h, actual 0x%h",
                     name, vec_idx, expected.raw, actual.raw);
            vec_errors++;
        end
    endtask

    // ==============================
    // Vector file
    // ==============================

    task automatic load_vectors();
        int           fd;
        int           line_no;
        int           n;
        string        line;
        logic [2:0]   f_cmd;
        logic [31:0]  f_addr;
        cache_block_t f_data;
        logic         f_hit;
        cache_block_t f_rdata;
        logic         f_ev_valid;
        logic         f_ev_dirty;
        logic [31:0]  f_ev_addr;
        cache_block_t f_ev_data;
        fd = $fopen(VEC_FILE, "r");
        if (fd == 0) begin
            $display("could not open vector file %s", VEC_FILE);
            load_error = 1'b1;
        end else begin
            line_no = 0;
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                line_no++;
                // Comment and blank lines hold no request
                if (n > 0 && line[0] != "#" && line[0] != "\n") begin
                    n = $sscanf(line, "%h %h %h %h %h %h %h %h %h",
                                f_cmd, f_addr, f_data, f_hit, f_rdata,
                                f_ev_valid, f_ev_dirty, f_ev_addr, f_ev_data);
                    if (n != 9) begin
                        $display("malformed line %0d in vector file, %0d of 9 fields read",
                                 line_no, n);
                        load_error = 1'b1;
                    end else begin
                        vec_cmd.push_back(f_cmd);
                        vec_addr.push_back(f_addr);
                        vec_data.push_back(f_data);
                        vec_hit.push_back(f_hit);
                        vec_rdata.push_back(f_rdata);
                        vec_ev_valid.push_back(f_ev_valid);
                        vec_ev_dirty.push_back(f_ev_dirty);
                        vec_ev_addr.push_back(f_ev_addr);
                        vec_ev_data.push_back(f_ev_data);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // One request, driven after the edge and checked before the next one
    task automatic run_vector(input int idx);
        @(posedge clk);
        #DRIVE_DLY;
        req_cmd  = req_cmd_e'(vec_cmd[idx]);
        req_addr = vec_addr[idx];
        req_data = vec_data[idx];
        #SAMPLE_DLY;
        vec_idx    = idx;
        vec_errors = 0;
        check_bit("req_hit_o", vec_hit[idx], req_hit);
        check_block("req_data_o", vec_rdata[idx], req_rdata);
        check_bit("evict_valid_o", vec_ev_valid[idx], evict_valid);
        check_bit("evict_dirty_o", vec_ev_dirty[idx], evict_dirty);
        check_addr("evict_addr_o", vec_ev_addr[idx], evict_addr);
        check_block("evict_data_o", vec_ev_data[idx], evict_data);
        if (vec_errors == 0) begin
            pass_count++;
            $display("vector %0d cmd %0d addr 0x%h passed", idx, vec_cmd[idx], vec_addr[idx]);
        end else begin
            fail_count++;
            $display("vector %0d cmd %0d addr 0x%h failed with %0d mismatches",
                     idx, vec_cmd[idx], vec_addr[idx], vec_errors);
        end
    endtask

    // ==============================
    // Main sequence
    // ==============================

    initial begin
        clk        = 1'b0;
        rst        = 1'b1;
        req_cmd    = REQ_NONE;
        req_addr   = '0;
        req_data   = '0;
        vec_idx    = 0;
        vec_errors = 0;
        pass_count = 0;
        fail_count = 0;
        load_error = 1'b0;
        loaded     = 1'b0;
        load_vectors();
        loaded = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        #DRIVE_DLY;
        rst = 1'b0;
        foreach (vec_cmd[i]) begin
            run_vector(i);
        end
        $display("%0d vectors passed, %0d vectors failed", pass_count, fail_count);
        if (fail_count == 0 && !load_error && vec_cmd.size() > 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // Watchdog, limit scales with the number of vectors read
    initial begin
        int limit_cycles;
        wait (loaded);
        limit_cycles = vec_cmd.size() + SLACK_CYCLES;
        #(limit_cycles * CLK_PERIOD);
        $display("timeout, the run did not end within %0d cycles", limit_cycles);
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* verif/cache_input.txt */
# cmd(0 none,1 load,2 store,3 load-miss,4 store-miss) addr data | hit rdata
# | evict_valid evict_dirty evict_addr evict_data, all fields hex
# Idle and cold miss after reset
0 00000000 0000000000000000 0 0000000000000000 0 0 00000000 0000000000000000
1 00000208 0000000000000000 0 0000000000000000 0 0 00000000 0000000000000000
# Set 1 fills take ways 3 2 1 0, hit with nonzero offset
3 00000208 a1a1a1a100000010 0 0000000000000000 0 0 00000000 0000000000000000
1 0000020c 0000000000000000 1 a1a1a1a100000010 0 0 00000000 0000000000000000
3 00000228 a2a2a2a200000011 0 0000000000000000 0 0 00000000 0000000000000000
4 00000248 a3a3a3a300000012 0 0000000000000000 0 0 00000000 0000000000000000
3 00000268 a4a4a4a400000013 0 0000000000000000 0 0 00000000 0000000000000000
# Store hit returns old data, load sees new data
2 00000228 b2b2b2b200000011 1 a2a2a2a200000011 0 0 00000000 0000000000000000
1 00000228 0000000000000000 1 b2b2b2b200000011 0 0 00000000 0000000000000000
# Touch way 0, fifth tag evicts clean way 3
1 00000268 0000000000000000 1 a4a4a4a400000013 0 0 00000000 0000000000000000
3 00000288 a5a5a5a500000014 0 0000000000000000 1 0 00000208 a1a1a1a100000010
1 00000208 0000000000000000 0 0000000000000000 0 0 00000000 0000000000000000
# Dirty victims from store-miss fill and store hit
3 00000208 a6a6a6a600000010 0 0000000000000000 1 1 00000248 a3a3a3a300000012
3 000002a8 a7a7a7a700000015 0 0000000000000000 1 1 00000228 b2b2b2b200000011
# Store-miss to a present line acts as a store hit
4 00000288 b5b5b5b500000014 1 a5a5a5a500000014 0 0 00000000 0000000000000000
1 00000288 0000000000000000 1 b5b5b5b500000014 0 0 00000000 0000000000000000
# Store-miss fill over a clean victim, then a load-miss fill
4 000002c8 a8a8a8a800000016 0 0000000000000000 1 0 00000268 a4a4a4a400000013
3 000002e8 a9a9a9a900000017 0 0000000000000000 1 0 00000208 a6a6a6a600000010
# Set 2 fills and evicts on its own
3 00000410 c1c1c1c100000020 0 0000000000000000 0 0 00000000 0000000000000000
3 00000430 c2c2c2c200000021 0 0000000000000000 0 0 00000000 0000000000000000
3 00000450 c3c3c3c300000022 0 0000000000000000 0 0 00000000 0000000000000000
3 00000470 c4c4c4c400000023 0 0000000000000000 0 0 00000000 0000000000000000
3 00000490 c5c5c5c500000024 0 0000000000000000 1 0 00000410 c1c1c1c100000020
# Set 1 order unchanged by set 2 traffic
1 000002a8 0000000000000000 1 a7a7a7a700000015 0 0 00000000 0000000000000000
3 00000308 aaaaaaaa00000018 0 0000000000000000 1 1 00000288 b5b5b5b500000014
3 00000328 abababab00000019 0 0000000000000000 1 1 000002c8 a8a8a8a800000016
1 000002e8 0000000000000000 1 a9a9a9a900000017 0 0 00000000 0000000000000000
# Sets 0 and 3, store miss writes nothing
1 00000000 0000000000000000 0 0000000000000000 0 0 00000000 0000000000000000
2 00000018 d0d0d0d000000000 0 0000000000000000 0 0 00000000 0000000000000000
1 00000018 0000000000000000 0 0000000000000000 0 0 00000000 0000000000000000
4 00000018 d1d1d1d100000003 0 0000000000000000 0 0 00000000 0000000000000000
1 0000001c 0000000000000000 1 d1d1d1d100000003 0 0 00000000 0000000000000000
# Idle command on a present line reports nothing
0 000002a8 0000000000000000 0 0000000000000000 0 0 00000000 0000000000000000
# Final lookups across sets
1 00000490 0000000000000000 1 c5c5c5c500000024 0 0 00000000 0000000000000000
1 00000410 0000000000000000 0 0000000000000000 0 0 00000000 0000000000000000
1 00000328 0000000000000000 1 abababab00000019 0 0 00000000 0000000000000000

/* Makefile */
# Verilator build for the cache memory array testbench
# Any variable can be overridden on the command line, e.g. make run TOP=cache_mem_tb
# The run target fails unless the simulation prints the pass message

VERILATOR ?= verilator
TOP       ?= cache_mem_tb
FILELIST  ?= cache_mem.f
OBJ_DIR   ?= obj_dir
FLAGS     ?= -j 0 -Wno-fatal
PASS_MSG  ?= TEST OK

SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

# Build the simulation binary
compile:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Run and search the output for the pass message
run: compile
	@out="$$($(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)" || { echo "simulation did not pass"; exit 1; }

clean:
	rm -rf $(OBJ_DIR)

/* cache_mem.f */
verilog/cache_pkg.sv
verilog/way_lookup.sv
verilog/victim_select.sv
verilog/line_update.sv
verilog/cache_mem.sv
verif/cache_mem_tb.sv
